// File: Makefile
TOP = tb_rram_ctrl

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f rram_ctrl_top.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: rram_ctrl_top.f
+incdir+src
src/rram_pkg.sv
src/array_ctrl_if.sv
src/instr_mem.sv
src/pc_counter.sv
src/ctrl_fsm.sv
src/array_driver.sv
src/read_buffer.sv
src/rram_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rram_ctrl.sv

// File: src/array_ctrl_if.sv
`timescale 1ns/1ps

interface array_ctrl_if;
  import rram_pkg::*;

  // Phase is a per-cycle level, fields only matter in WRITE/PRECHARGE/SENSE
  drive_phase_t phase;
  cell_idx_t    row;
  cell_idx_t    col;
  logic         set_bit;
  logic         col_half;

  modport ctrl (
    output phase, row, col, set_bit, col_half
  );

  modport driver (
    input phase, row, col, set_bit, col_half
  );

endinterface

// File: src/array_driver.sv
`timescale 1ns/1ps
`include "rram_cfg.svh"

module array_driver (
  input  logic            clk,
  input  logic            rst,
  array_ctrl_if.driver    drv,
  output rram_pkg::line_t bl_in0,
  output rram_pkg::line_t bl_in1,
  output rram_pkg::line_t sl_in0,
  output rram_pkg::line_t sl_in1,
  output rram_pkg::line_t wl_in0,
  output rram_pkg::line_t wl_in1,
  output logic            wl_en,
  output logic            bl_en,
  output logic            sl_en,
  output logic            pre,
  output logic            sa_en,
  output logic            col_select
);
  import rram_pkg::*;

  line_t row_hot;
  line_t col_hot;
  line_t half_mask;
  line_t bl0_d, bl1_d, sl0_d, sl1_d, wl0_d, wl1_d;
  logic  wl_en_d, bl_en_d, sl_en_d, pre_d, sa_en_d, col_sel_d;
  logic  sensing;

  assign row_hot   = line_t'(1) << drv.row;
  assign col_hot   = line_t'(1) << drv.col;
  assign half_mask = {{(`RRAM_ARRAY_SIZE/2){drv.col_half}},
                      {(`RRAM_ARRAY_SIZE/2){~drv.col_half}}};
  assign sensing   = (drv.phase == PH_SENSE);

  // 11 on a pair is ground, HOLD falls through to the current values
  always_comb begin
    bl0_d = bl_in0;  bl1_d = bl_in1;
    sl0_d = sl_in0;  sl1_d = sl_in1;
    wl0_d = wl_in0;  wl1_d = wl_in1;
    wl_en_d = wl_en; bl_en_d = bl_en; sl_en_d = sl_en;
    pre_d = pre;     sa_en_d = sa_en; col_sel_d = col_select;
    case (drv.phase)
      PH_PARK: begin
        bl0_d = '1; bl1_d = '1; sl0_d = '1; sl1_d = '1; wl0_d = '1; wl1_d = '1;
        wl_en_d = 1'b0; bl_en_d = 1'b0; sl_en_d = 1'b0;
        pre_d = 1'b1; sa_en_d = 1'b0;
      end
      PH_WRITE: begin
        // Selected row at 01
        wl0_d = ~row_hot;
        wl1_d = '1;
        if (drv.set_bit) begin
          // SET drives the bit line to 00, source line grounded
          bl0_d = ~col_hot; bl1_d = ~col_hot; sl0_d = '1; sl1_d = '1;
        end else begin
          // RESET drives the source line to 01, bit line grounded
          bl0_d = '1; bl1_d = '1; sl0_d = ~col_hot; sl1_d = '1;
        end
        wl_en_d = 1'b1; bl_en_d = 1'b1; sl_en_d = 1'b1;
        pre_d = 1'b1; sa_en_d = 1'b0;
      end
      PH_PRECHARGE, PH_SENSE: begin
        // Same lines in both read steps, only the enables differ
        wl0_d = ~row_hot; wl1_d = ~row_hot;
        bl0_d = ~half_mask; bl1_d = '1;
        sl0_d = '1; sl1_d = '1;
        col_sel_d = drv.col_half;
        pre_d = sensing; wl_en_d = sensing; bl_en_d = sensing;
        sl_en_d = 1'b0; sa_en_d = sensing;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bl_in0 <= '1; bl_in1 <= '1;
      sl_in0 <= '1; sl_in1 <= '1;
      wl_in0 <= '1; wl_in1 <= '1;
      wl_en <= 1'b0; bl_en <= 1'b0; sl_en <= 1'b0;
      pre <= 1'b1; sa_en <= 1'b0; col_select <= 1'b0;
    end else begin
      bl_in0 <= bl0_d; bl_in1 <= bl1_d;
      sl_in0 <= sl0_d; sl_in1 <= sl1_d;
      wl_in0 <= wl0_d; wl_in1 <= wl1_d;
      wl_en <= wl_en_d; bl_en <= bl_en_d; sl_en <= sl_en_d;
      pre <= pre_d; sa_en <= sa_en_d; col_select <= col_sel_d;
    end
  end

endmodule

// File: src/ctrl_fsm.sv
`timescale 1ns/1ps
`include "rram_cfg.svh"

module ctrl_fsm (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable_pc,
  input  logic             at_end,
  input  rram_pkg::instr_t instr,
  output logic             load,
  output logic             step,
  output logic             busy,
  output logic             capture,
  array_ctrl_if.ctrl       drv
);
  import rram_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_d;
  opcode_t     op;
  logic        wr_pulse;
  logic        run_done;
  cell_idx_t   row_q;
  cell_idx_t   col_q;
  logic        set_q;
  logic        half_q;

  assign op = instr[`RRAM_OP_MSB:`RRAM_OP_LSB];

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  always_comb begin
    state_d = state;
    load    = 1'b0;
    step    = 1'b0;
    case (state)
      ST_IDLE: begin
        if (enable_pc && !run_done) begin
          load    = 1'b1;
          state_d = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (at_end || !enable_pc) begin
          state_d = ST_IDLE;
        end else begin
          step    = 1'b1;
          state_d = ST_DECODE;
        end
      end
      // IDLE and config words also use the one execute slot
      ST_DECODE:       state_d = (op == `RRAM_OP_READ) ? ST_READ_PRE : ST_WRITE_PULSE;
      ST_WRITE_PULSE:  state_d = ST_FETCH;
      ST_READ_PRE:     state_d = ST_READ_SENSE;
      ST_READ_SENSE:   state_d = ST_READ_CAPTURE;
      ST_READ_CAPTURE: state_d = ST_FETCH;
      default:         state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state    <= ST_IDLE;
      wr_pulse <= 1'b0;
      run_done <= 1'b0;
    end else begin
      state <= state_d;
      if (state == ST_DECODE) begin
        wr_pulse <= (op == `RRAM_OP_WRITE);
      end
      // A finished run waits for the run level to drop before restarting
      if (state == ST_FETCH && state_d == ST_IDLE) begin
        run_done <= 1'b1;
      end else if (!enable_pc) begin
        run_done <= 1'b0;
      end
    end
  end

  // Field split, held through the execute cycles
  always_ff @(posedge clk) begin
    if (state == ST_DECODE) begin
      col_q  <= instr[`RRAM_WR_COL];
      set_q  <= instr[`RRAM_WR_DATA];
      half_q <= instr[`RRAM_RD_HALF];
      if (op == `RRAM_OP_READ) begin
        row_q <= instr[`RRAM_RD_ROW];
      end else begin
        row_q <= instr[`RRAM_WR_ROW];
      end
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign busy    = (state != ST_IDLE);
  assign capture = (state == ST_READ_CAPTURE);

  // FETCH parks so a write pulse lasts one cycle and read lines drop
  always_comb begin
    case (state)
      ST_IDLE, ST_FETCH: drv.phase = PH_PARK;
      ST_WRITE_PULSE:    drv.phase = wr_pulse ? PH_WRITE : PH_PARK;
      ST_READ_PRE:       drv.phase = PH_PRECHARGE;
      ST_READ_SENSE:     drv.phase = PH_SENSE;
      default:           drv.phase = PH_HOLD;
    endcase
  end

  assign drv.row      = row_q;
  assign drv.col      = col_q;
  assign drv.set_bit  = set_q;
  assign drv.col_half = half_q;

endmodule

// File: src/instr_mem.sv
`timescale 1ns/1ps
`include "rram_cfg.svh"

module instr_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  rram_pkg::instr_t    wr_data,
  input  rram_pkg::im_addr_t  rd_addr,
  output rram_pkg::instr_t    rd_data,
  output rram_pkg::im_count_t count,
  output logic                full,
  output logic                empty
);
  import rram_pkg::*;

  instr_t mem [`RRAM_IM_DEPTH];
  im_addr_t wr_ptr;

  // Words are appended in load order
  assign wr_ptr = count[`RRAM_IM_ADDR_W-1:0];
  assign full   = (count == im_count_t'(`RRAM_IM_DEPTH));
  assign empty  = (count == '0);

  //////////////////////////////
  // Host load side
  //////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      count <= '0;
    end else if (wr_en && !full) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !full) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  //////////////////////////////
  // Fetch side
  //////////////////////////////

  // Word at rd_addr shows up one cycle later (DECODE)
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src/pc_counter.sv
`timescale 1ns/1ps

module pc_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  rram_pkg::im_addr_t  start_addr,
  input  logic                step,
  input  rram_pkg::im_count_t limit,
  output rram_pkg::im_addr_t  pc,
  output logic                at_end
);
  import rram_pkg::*;

  // One extra bit so a full memory still reaches the limit
  im_count_t pc_ext;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc_ext <= '0;
    end else if (load) begin
      pc_ext <= im_count_t'(start_addr);
    end else if (step) begin
      pc_ext <= pc_ext + 1'b1;
    end
  end

  assign pc = pc_ext[$bits(im_addr_t)-1:0];

  // Also covers a start address past the loaded words
  assign at_end = (pc_ext >= limit);

endmodule

// File: src/read_buffer.sv
`timescale 1ns/1ps
`include "rram_cfg.svh"

module read_buffer (
  input  logic                clk,
  input  logic                rst,
  input  logic                capture,
  input  rram_pkg::sense_t    csa,
  input  logic                rd_en,
  input  rram_pkg::ob_addr_t  rd_addr,
  output rram_pkg::sense_t    rd_data,
  output rram_pkg::ob_count_t count
);
  import rram_pkg::*;

  sense_t   mem [`RRAM_OB_DEPTH];
  ob_addr_t wr_ptr;
  logic     full;

  assign wr_ptr = count[`RRAM_OB_ADDR_W-1:0];
  assign full   = (count == ob_count_t'(`RRAM_OB_DEPTH));

  // Captures past the last slot are dropped
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      count <= '0;
    end else if (capture && !full) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture && !full) begin
      mem[wr_ptr] <= csa;
    end
  end

  // Host read, data valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: src/rram_cfg.svh
`ifndef RRAM_CFG_SVH
`define RRAM_CFG_SVH

// Array geometry
`define RRAM_ARRAY_SIZE   16
`define RRAM_IDX_W        4

// Word and memory sizes
`define RRAM_INSTR_W      32
`define RRAM_IM_ADDR_W    7
`define RRAM_OB_ADDR_W    7
`define RRAM_IM_DEPTH     (1 << `RRAM_IM_ADDR_W)
`define RRAM_OB_DEPTH     (1 << `RRAM_OB_ADDR_W)

// Opcodes in the top nibble
`define RRAM_OP_MSB       31
`define RRAM_OP_LSB       28
`define RRAM_OP_IDLE      4'h0
`define RRAM_OP_WRITE     4'h1
`define RRAM_OP_READ      4'h2

// WRITE fields
`define RRAM_WR_COL       3:0
`define RRAM_WR_ROW       7:4
`define RRAM_WR_DATA      8

// READ fields, half 0 is columns 7..0
`define RRAM_RD_HALF      0
`define RRAM_RD_ROW       4:1

`endif

// File: src/rram_ctrl_top.sv
`timescale 1ns/1ps

module rram_ctrl_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                im_wr_en,
  input  rram_pkg::instr_t    im_wr_data,
  output logic                im_full,
  output logic                im_empty,
  input  logic                enable_pc,
  input  rram_pkg::im_addr_t  start_pc_addr,
  output logic                busy,
  output rram_pkg::line_t     bl_in0,
  output rram_pkg::line_t     bl_in1,
  output rram_pkg::line_t     sl_in0,
  output rram_pkg::line_t     sl_in1,
  output rram_pkg::line_t     wl_in0,
  output rram_pkg::line_t     wl_in1,
  output logic                wl_en,
  output logic                bl_en,
  output logic                sl_en,
  output logic                pre,
  output logic                sa_en,
  output logic                col_select,
  input  rram_pkg::sense_t    csa,
  input  logic                out_rd_en,
  input  rram_pkg::ob_addr_t  out_rd_addr,
  output rram_pkg::sense_t    out_rd_data,
  output rram_pkg::ob_count_t out_count
);
  import rram_pkg::*;

  instr_t    instr;
  im_count_t im_count;
  im_addr_t  pc;
  logic      at_end;
  logic      pc_load;
  logic      pc_step;
  logic      capture;

  array_ctrl_if drv_if ();

  instr_mem u_instr_mem (
    .clk(clk), .rst(rst),
    .wr_en(im_wr_en), .wr_data(im_wr_data),
    .rd_addr(pc), .rd_data(instr),
    .count(im_count), .full(im_full), .empty(im_empty)
  );

  pc_counter u_pc_counter (
    .clk(clk), .rst(rst),
    .load(pc_load), .start_addr(start_pc_addr), .step(pc_step),
    .limit(im_count), .pc(pc), .at_end(at_end)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk(clk), .rst(rst),
    .enable_pc(enable_pc), .at_end(at_end), .instr(instr),
    .load(pc_load), .step(pc_step), .busy(busy), .capture(capture),
    .drv(drv_if.ctrl)
  );

  array_driver u_array_driver (
    .clk(clk), .rst(rst), .drv(drv_if.driver),
    .bl_in0(bl_in0), .bl_in1(bl_in1), .sl_in0(sl_in0), .sl_in1(sl_in1),
    .wl_in0(wl_in0), .wl_in1(wl_in1),
    .wl_en(wl_en), .bl_en(bl_en), .sl_en(sl_en),
    .pre(pre), .sa_en(sa_en), .col_select(col_select)
  );

  read_buffer u_read_buffer (
    .clk(clk), .rst(rst),
    .capture(capture), .csa(csa),
    .rd_en(out_rd_en), .rd_addr(out_rd_addr), .rd_data(out_rd_data),
    .count(out_count)
  );

endmodule

// File: src/rram_pkg.sv
`include "rram_cfg.svh"

package rram_pkg;

  typedef logic [`RRAM_INSTR_W-1:0]    instr_t;
  typedef logic [`RRAM_ARRAY_SIZE-1:0] line_t;
  typedef logic [`RRAM_ARRAY_SIZE-1:0] sense_t;
  typedef logic [`RRAM_IM_ADDR_W-1:0]  im_addr_t;
  typedef logic [`RRAM_IM_ADDR_W:0]    im_count_t;
  typedef logic [`RRAM_OB_ADDR_W-1:0]  ob_addr_t;
  typedef logic [`RRAM_OB_ADDR_W:0]    ob_count_t;
  typedef logic [`RRAM_IDX_W-1:0]      cell_idx_t;
  typedef logic [`RRAM_OP_MSB-`RRAM_OP_LSB:0] opcode_t;

  // Controller sequence
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_WRITE_PULSE,
    ST_READ_PRE,
    ST_READ_SENSE,
    ST_READ_CAPTURE
  } ctrl_state_t;

  // What the array driver applies on the next edge
  typedef enum logic [2:0] {
    PH_PARK,
    PH_WRITE,
    PH_PRECHARGE,
    PH_SENSE,
    PH_HOLD
  } drive_phase_t;

endpackage

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Active low for 5 cycles, released just after an edge
  initial begin
    rst = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b1;
  end

endmodule

// File: testbench/tb_rram_ctrl.sv
`timescale 1ns/1ps
`include "rram_cfg.svh"

module tb_rram_ctrl;
  import rram_pkg::*;

  localparam int N_WORDS = 5 + 4 + 9 + 60;
  localparam int CYCLE_LIMIT = 5 * N_WORDS + 200;

  typedef struct packed {
    line_t bl0, bl1, sl0, sl1, wl0, wl1;
  } drive_t;

  logic clk, rst, im_wr_en, enable_pc, out_rd_en;
  logic im_full, im_empty, busy, wl_en, bl_en, sl_en, pre, sa_en, col_select;
  instr_t im_wr_data;
  im_addr_t start_pc_addr;
  ob_addr_t out_rd_addr;
  sense_t csa, out_rd_data;
  ob_count_t out_count, exp_count;
  line_t bl_in0, bl_in1, sl_in0, sl_in1, wl_in0, wl_in1;
  line_t cells [`RRAM_ARRAY_SIZE];
  line_t shadow [`RRAM_ARRAY_SIZE];
  logic [8:0] wr_q [$];
  logic [4:0] rd_q [$];
  sense_t sense_q [$];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int loaded = 0;
  int exp_busy = 1;
  integer seed;
  logic wr_prev = 1'b0;
  logic sa_prev = 1'b0;

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));
  rram_ctrl_top dut_i (.*);

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic match_line(input string name, input line_t got, input line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic verify_sense(input string name, input sense_t got, input sense_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input ob_count_t got, input ob_count_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic verify_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_drive(input drive_t exp);
    match_line("bl_in0", bl_in0, exp.bl0);
    match_line("bl_in1", bl_in1, exp.bl1);
    match_line("sl_in0", sl_in0, exp.sl0);
    match_line("sl_in1", sl_in1, exp.sl1);
    match_line("wl_in0", wl_in0, exp.wl0);
    match_line("wl_in1", wl_in1, exp.wl1);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Selected row 01, SET puts 00 on the bit line, RESET 01 on the source line
  function automatic drive_t lines_for_write(input cell_idx_t row, input cell_idx_t col,
                                             input logic set);
    drive_t d;
    for (int i = 0; i < `RRAM_ARRAY_SIZE; i++) begin
      d.wl0[i] = (i != row);
      d.wl1[i] = 1'b1;
      d.bl0[i] = !(i == col && set);
      d.bl1[i] = !(i == col && set);
      d.sl0[i] = !(i == col && !set);
      d.sl1[i] = 1'b1;
    end
    return d;
  endfunction

  // Precharge and sense share these lines
  function automatic drive_t lines_for_read(input cell_idx_t row, input logic half);
    drive_t d;
    for (int i = 0; i < `RRAM_ARRAY_SIZE; i++) begin
      d.wl0[i] = (i != row);
      d.wl1[i] = (i != row);
      d.bl0[i] = ((i / 8) != half);
      d.bl1[i] = 1'b1;
      d.sl0[i] = 1'b1;
      d.sl1[i] = 1'b1;
    end
    return d;
  endfunction

  function automatic sense_t sense_of_row(input cell_idx_t row, input logic half);
    sense_t w;
    w = '0;
    for (int j = 0; j < 8; j++) begin
      w[j] = shadow[row][half * 8 + j];
    end
    return w;
  endfunction

  //////////////////////////////
  // Program load and run
  //////////////////////////////

  task automatic load_word(input instr_t w);
    im_wr_en = 1'b1;
    im_wr_data = w;
    @(posedge clk);
    #2;
    im_wr_en = 1'b0;
    loaded++;
    expect_bit("im_empty", im_empty, 1'b0);
    expect_bit("im_full", im_full, loaded >= `RRAM_IM_DEPTH);
  endtask

  // Three cycles per word, two more for a read
  task automatic add_write(input cell_idx_t row, input cell_idx_t col, input logic set);
    instr_t w;
    w = '0;
    w[`RRAM_OP_MSB:`RRAM_OP_LSB] = `RRAM_OP_WRITE;
    w[`RRAM_WR_ROW] = row;
    w[`RRAM_WR_COL] = col;
    w[`RRAM_WR_DATA] = set;
    wr_q.push_back({set, row, col});
    shadow[row][col] = set;
    exp_busy += 3;
    load_word(w);
  endtask

  task automatic add_read(input cell_idx_t row, input logic half);
    instr_t w;
    w = '0;
    w[`RRAM_OP_MSB:`RRAM_OP_LSB] = `RRAM_OP_READ;
    w[`RRAM_RD_ROW] = row;
    w[`RRAM_RD_HALF] = half;
    rd_q.push_back({row, half});
    sense_q.push_back(sense_of_row(row, half));
    exp_count++;
    exp_busy += 5;
    load_word(w);
  endtask

  task automatic add_idle(input logic [27:0] filler);
    exp_busy += 3;
    load_word({`RRAM_OP_IDLE, filler});
  endtask

  // Busy spans every instruction plus the final fetch
  task automatic run_program(input int start);
    int span;
    span = 0;
    start_pc_addr = im_addr_t'(start);
    enable_pc = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!busy);
    while (busy) begin
      span++;
      @(posedge clk);
      #2;
    end
    enable_pc = 1'b0;
    @(posedge clk);
    #2;
    verify_cycles("busy cycles", span, exp_busy);
    compare_count("out_count", out_count, exp_count);
    exp_busy = 1;
  endtask

  // One word per cycle with registered data
  task automatic read_back(input int first);
    for (int a = first; a < exp_count; a++) begin
      out_rd_en = 1'b1;
      out_rd_addr = ob_addr_t'(a);
      @(posedge clk);
      #2;
      out_rd_en = 1'b0;
      verify_sense("out_rd_data", out_rd_data, sense_q.pop_front());
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    if (wr_q.size() != 0 || rd_q.size() != 0) begin
      errors++;
      $display("%0d write pulses and %0d sense cycles never appeared", wr_q.size(), rd_q.size());
      wr_q.delete();
      rd_q.delete();
    end
    $display("test %s: %0d errors", name, errors - err_start);
  endtask

  //////////////////////////////
  // Array model and checker
  //////////////////////////////

  always @(posedge clk) begin
    #1;
    if (wl_en && bl_en && sl_en) begin
      for (int r = 0; r < `RRAM_ARRAY_SIZE; r++) begin
        for (int c = 0; c < `RRAM_ARRAY_SIZE; c++) begin
          if (!wl_in0[r] && wl_in1[r] && !bl_in0[c] && !bl_in1[c]) cells[r][c] = 1'b1;
          if (!wl_in0[r] && wl_in1[r] && !sl_in0[c] && sl_in1[c]) cells[r][c] = 1'b0;
        end
      end
    end
    #1;
    csa = '0;
    for (int r = 0; r < `RRAM_ARRAY_SIZE; r++) begin
      if (sa_en && !wl_in0[r] && !wl_in1[r]) begin
        for (int j = 0; j < 8; j++) begin
          csa[j] = cells[r][col_select * 8 + j];
        end
      end
    end
  end

  // Each new write pulse or sense cycle against the next expected one
  always @(posedge clk) begin : pulse_check
    logic [8:0] w;
    logic [4:0] r;
    #1;
    if (wl_en && bl_en && sl_en) begin
      if (wr_prev) begin
        errors++;
        $display("Write pulse at %0t ns lasted more than one cycle", $time);
      end else if (wr_q.size() == 0) begin
        errors++;
        $display("Unexpected write pulse at %0t ns", $time);
      end else begin
        w = wr_q.pop_front();
        compare_drive(lines_for_write(w[7:4], w[3:0], w[8]));
      end
    end
    if (sa_en && !sa_prev) begin
      if (rd_q.size() == 0) begin
        errors++;
        $display("Unexpected sense cycle at %0t ns", $time);
      end else begin
        r = rd_q.pop_front();
        compare_drive(lines_for_read(r[4:1], r[0]));
        expect_bit("pre", pre, 1'b1);
        expect_bit("wl_en", wl_en, 1'b1);
        expect_bit("bl_en", bl_en, 1'b1);
        expect_bit("sl_en", sl_en, 1'b0);
        expect_bit("col_select", col_select, r[0]);
      end
    end
    wr_prev = wl_en && bl_en && sl_en;
    sa_prev = sa_en;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    int err0;
    int base;
    int first;
    integer kind;
    integer f;
    seed = 32'had49;
    exp_count = '0;
    for (int i = 0; i < `RRAM_ARRAY_SIZE; i++) begin
      cells[i] = '0;
      shadow[i] = '0;
    end
    im_wr_en = 1'b0;
    im_wr_data = '0;
    enable_pc = 1'b0;
    start_pc_addr = '0;
    csa = '0;
    out_rd_en = 1'b0;
    out_rd_addr = '0;
    wait (rst === 1'b1);

    // Parked array straight out of reset
    err0 = errors;
    compare_drive('1);
    expect_bit("wl_en", wl_en, 1'b0);
    expect_bit("bl_en", bl_en, 1'b0);
    expect_bit("sl_en", sl_en, 1'b0);
    expect_bit("sa_en", sa_en, 1'b0);
    expect_bit("pre", pre, 1'b1);
    expect_bit("busy", busy, 1'b0);
    expect_bit("im_empty", im_empty, 1'b1);
    compare_count("out_count", out_count, '0);
    end_test("1 reset", err0);

    err0 = errors;
    base = loaded;
    add_write(2, 5, 1'b1);
    add_write(2, 11, 1'b1);
    add_write(9, 0, 1'b1);
    add_write(2, 5, 1'b0);
    add_write(15, 15, 1'b1);
    run_program(base);
    end_test("2 write pulses", err0);

    err0 = errors;
    base = loaded;
    first = exp_count;
    add_read(2, 1'b0);
    add_read(2, 1'b1);
    add_read(9, 1'b0);
    add_read(15, 1'b1);
    run_program(base);
    read_back(first);
    end_test("3 reads", err0);

    // IDLE padding ahead of the program, skipped by the start address
    err0 = errors;
    add_idle(28'h0);
    add_idle(28'h123_4567);
    add_idle(28'hfff_ffff);
    // Padding words are never fetched
    exp_busy = 1;
    base = loaded;
    first = exp_count;
    add_write(4, 3, 1'b1);
    add_read(4, 1'b0);
    add_idle(28'h0);
    add_read(4, 1'b1);
    add_write(4, 3, 1'b0);
    add_read(4, 1'b0);
    run_program(base);
    read_back(first);
    end_test("4 start address and end", err0);

    err0 = errors;
    base = loaded;
    first = exp_count;
    repeat (60) begin
      kind = $random(seed);
      f = $random(seed);
      case ($unsigned(kind) % 3)
        0: add_write(f[3:0], f[7:4], f[8]);
        1: add_read(f[3:0], f[4]);
        default: add_idle(f[27:0]);
      endcase
    end
    run_program(base);
    read_back(first);
    end_test("5 random program", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
